//--- rtl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////
	// colour and raster types
	////////////////////////////////////////

	// r=7:5, g=4:2, b=1:0
	typedef logic [7:0] rgb_t;

	// one pixel's raster position and decode
	typedef struct packed {
		logic [10:0] hcount;
		logic [9:0]  vcount;
		// active low
		logic        hsync;
		// active low
		logic        vsync;
		// high inside the visible area
		logic        video_on;
	} raster_t;

	// pattern select opcodes
	typedef enum logic [1:0] {
		PATTERN_PONG     = 2'd0,
		PATTERN_BORDER   = 2'd1,
		PATTERN_BARS     = 2'd2,
		PATTERN_PONG_ALT = 2'd3
	} pattern_e;

	localparam rgb_t COLOR_WHITE = 8'b111_111_11;
	localparam rgb_t COLOR_BLACK = 8'b000_000_00;

endpackage

//--- rtl/pong_pkg.sv
package pong_pkg;

	////////////////////////////////////////
	// game object types
	////////////////////////////////////////

	// object coordinates, same widths as the raster counters
	typedef logic [10:0] pos_x_t;
	typedef logic [9:0]  pos_y_t;

	// one puck's state
	typedef struct packed {
		pos_x_t x;
		pos_y_t y;
		logic   moving_right;
		// up means y decreasing
		logic   moving_up;
	} ball_t;

	// pixels per frame
	typedef logic [4:0] speed_t;

	////////////////////////////////////////
	// object colours
	////////////////////////////////////////

	localparam video_pkg::rgb_t COLOR_BALL_A = 8'b111_000_11;
	localparam video_pkg::rgb_t COLOR_BALL_B = 8'b111_111_00;
	localparam video_pkg::rgb_t COLOR_PADDLE = 8'b000_111_00;

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 1024,
	parameter int H_FP     = 24,
	parameter int H_SYNC   = 136,
	parameter int H_BP     = 160,
	parameter int V_ACTIVE = 768,
	parameter int V_FP     = 3,
	parameter int V_SYNC   = 6,
	parameter int V_BP     = 29
) (
	input  logic                pixel_clk,
	input  logic                reset,
	output video_pkg::raster_t  raster
);

	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam logic [10:0] H_LAST = 11'(H_TOTAL - 1);
	localparam logic [9:0]  V_LAST = 10'(V_TOTAL - 1);

	logic [10:0] hcount;
	logic [9:0]  vcount;

	// pixel counter, line counter steps at end of line
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == H_LAST) begin
			hcount <= '0;
			vcount <= (vcount == V_LAST) ? 10'd0 : vcount + 10'd1;
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	// same-cycle decode
	always_comb begin
		raster.hcount   = hcount;
		raster.vcount   = vcount;
		// sync pulses sit after the front porch, active low
		raster.hsync    = !((hcount >= H_ACTIVE + H_FP) && (hcount < H_ACTIVE + H_FP + H_SYNC));
		raster.vsync    = !((vcount >= V_ACTIVE + V_FP) && (vcount < V_ACTIVE + V_FP + V_SYNC));
		raster.video_on = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
	end

	// counter never runs past the line length
	hcount_in_range: assert property (@(posedge pixel_clk) disable iff (reset)
		hcount < H_TOTAL);

endmodule

//--- rtl/ball_motion.sv
`timescale 1ns/1ps

module ball_motion #(
	parameter int H_ACTIVE  = 1024,
	parameter int V_ACTIVE  = 768,
	parameter int BALL_SIZE = 64,
	parameter int START_X   = 256,
	parameter int START_Y   = 192
) (
	input  logic             pixel_clk,
	input  logic             reset,
	input  logic             frame_tick,
	input  pong_pkg::speed_t speed_x,
	input  pong_pkg::speed_t speed_y,
	output pong_pkg::ball_t  ball
);

	// top left corner limits
	localparam int X_MAX = H_ACTIVE - BALL_SIZE;
	localparam int Y_MAX = V_ACTIVE - BALL_SIZE;

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			ball.x            <= pong_pkg::pos_x_t'(START_X);
			ball.y            <= pong_pkg::pos_y_t'(START_Y);
			ball.moving_right <= 1'b0;
			ball.moving_up    <= 1'b1;
		end else if (frame_tick) begin
			////////////////////////////////////////
			// horizontal
			if (ball.moving_right) begin
				// past right edge, clamp and turn back
				if (ball.x + speed_x > X_MAX) begin
					ball.x            <= pong_pkg::pos_x_t'(X_MAX);
					ball.moving_right <= 1'b0;
				end else begin
					ball.x <= ball.x + pong_pkg::pos_x_t'(speed_x);
				end
			end else if (ball.x < speed_x) begin
				ball.x            <= '0;
				ball.moving_right <= 1'b1;
			end else begin
				ball.x <= ball.x - pong_pkg::pos_x_t'(speed_x);
			end
			////////////////////////////////////////
			// vertical, up is toward line 0
			if (ball.moving_up) begin
				if (ball.y < speed_y) begin
					ball.y         <= '0;
					ball.moving_up <= 1'b0;
				end else begin
					ball.y <= ball.y - pong_pkg::pos_y_t'(speed_y);
				end
			end else if (ball.y + speed_y > Y_MAX) begin
				ball.y         <= pong_pkg::pos_y_t'(Y_MAX);
				ball.moving_up <= 1'b1;
			end else begin
				ball.y <= ball.y + pong_pkg::pos_y_t'(speed_y);
			end
		end
	end

	// disk always fully on screen
	ball_in_bounds: assert property (@(posedge pixel_clk) disable iff (reset)
		(ball.x <= X_MAX) && (ball.y <= Y_MAX));

endmodule

//--- rtl/paddle_motion.sv
`timescale 1ns/1ps

module paddle_motion #(
	parameter int H_ACTIVE    = 1024,
	parameter int V_ACTIVE    = 768,
	parameter int PADDLE_SIZE = 20,
	parameter int PADDLE_STEP = 8
) (
	input  logic             pixel_clk,
	input  logic             reset,
	input  logic             frame_tick,
	input  logic             up,
	input  logic             down,
	input  logic             left,
	input  logic             right,
	output pong_pkg::pos_x_t paddle_x,
	output pong_pkg::pos_y_t paddle_y
);

	localparam int X_MAX = H_ACTIVE - PADDLE_SIZE;
	localparam int Y_MAX = V_ACTIVE - PADDLE_SIZE;

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			// start near the bottom right corner
			paddle_x <= pong_pkg::pos_x_t'(H_ACTIVE - 2 * PADDLE_SIZE);
			paddle_y <= pong_pkg::pos_y_t'(V_ACTIVE - 2 * PADDLE_SIZE);
		end else if (frame_tick) begin
			// up wins, a partial step is not taken
			if (up) begin
				if (paddle_y >= PADDLE_STEP)
					paddle_y <= paddle_y - pong_pkg::pos_y_t'(PADDLE_STEP);
			end else if (down) begin
				if (paddle_y + PADDLE_STEP <= Y_MAX)
					paddle_y <= paddle_y + pong_pkg::pos_y_t'(PADDLE_STEP);
			end
			// left wins
			if (left) begin
				if (paddle_x >= PADDLE_STEP)
					paddle_x <= paddle_x - pong_pkg::pos_x_t'(PADDLE_STEP);
			end else if (right) begin
				if (paddle_x + PADDLE_STEP <= X_MAX)
					paddle_x <= paddle_x + pong_pkg::pos_x_t'(PADDLE_STEP);
			end
		end
	end

endmodule

//--- rtl/round_puck.sv
`timescale 1ns/1ps

module round_puck #(
	parameter int              BALL_SIZE = 64,
	parameter video_pkg::rgb_t COLOR     = 8'b111_000_00
) (
	input  logic               pixel_clk,
	input  video_pkg::raster_t raster,
	input  pong_pkg::ball_t    ball,
	output video_pkg::rgb_t    pixel
);

	localparam int          RADIUS    = BALL_SIZE / 2;
	localparam logic [22:0] RADIUS_SQ = 23'(RADIUS * RADIUS);

	// disk centre, one bit of headroom
	logic [11:0] centre_x;
	logic [10:0] centre_y;
	logic [11:0] pix_x;
	logic [10:0] pix_y;
	// stage 1 distances
	logic [10:0] dist_x;
	logic [9:0]  dist_y;
	logic [22:0] dist_sq;

	always_comb begin
		centre_x = {1'b0, ball.x} + 12'(RADIUS);
		centre_y = {1'b0, ball.y} + 11'(RADIUS);
		pix_x    = {1'b0, raster.hcount};
		pix_y    = {1'b0, raster.vcount};
	end

	////////////////////////////////////////
	// stage 1, absolute distances
	always_ff @(posedge pixel_clk) begin
		dist_x <= (pix_x > centre_x) ? 11'(pix_x - centre_x) : 11'(centre_x - pix_x);
		dist_y <= (pix_y > centre_y) ? 10'(pix_y - centre_y) : 10'(centre_y - pix_y);
	end

	// squared distance, 22 bits each, sum in 23
	assign dist_sq = 23'(dist_x * dist_x) + 23'(dist_y * dist_y);

	////////////////////////////////////////
	// stage 2, inside test
	always_ff @(posedge pixel_clk) begin
		pixel <= (dist_sq <= RADIUS_SQ) ? COLOR : video_pkg::COLOR_BLACK;
	end

endmodule

//--- rtl/pong_game.sv
`timescale 1ns/1ps

module pong_game #(
	parameter int H_ACTIVE    = 1024,
	parameter int V_ACTIVE    = 768,
	parameter int BALL_SIZE   = 64,
	parameter int PADDLE_SIZE = 20,
	parameter int PADDLE_STEP = 8
) (
	input  logic               pixel_clk,
	input  logic               reset,
	input  logic               up,
	input  logic               down,
	input  logic               left,
	input  logic               right,
	input  logic [3:0]         pspeed,
	input  video_pkg::raster_t raster,
	output video_pkg::raster_t pong_raster,
	output video_pkg::rgb_t    pong_pixel
);

	logic             vsync_q;
	logic             frame_tick;
	pong_pkg::speed_t speed_x;
	pong_pkg::speed_t speed_y;
	pong_pkg::ball_t  ball_a;
	pong_pkg::ball_t  ball_b;
	video_pkg::rgb_t  puck_a_pixel;
	video_pkg::rgb_t  puck_b_pixel;
	pong_pkg::pos_x_t paddle_x;
	pong_pkg::pos_y_t paddle_y;
	logic [11:0]      paddle_x_end;
	logic [10:0]      paddle_y_end;
	logic             paddle_hit_q;
	video_pkg::rgb_t  paddle_pixel_q;
	video_pkg::raster_t raster_d1;

	////////////////////////////////////////
	// frame pulse on vsync falling edge
	always_ff @(posedge pixel_clk) begin
		if (reset)
			vsync_q <= 1'b1;
		else
			vsync_q <= raster.vsync;
	end
	assign frame_tick = vsync_q && !raster.vsync;

	// upper pair horizontal, lower pair vertical, doubled
	assign speed_x = pong_pkg::speed_t'({pspeed[3:2], 1'b0});
	assign speed_y = pong_pkg::speed_t'({pspeed[1:0], 1'b0});

	////////////////////////////////////////
	// objects
	ball_motion #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BALL_SIZE(BALL_SIZE),
		.START_X(H_ACTIVE / 4), .START_Y(V_ACTIVE / 4)) ball_a_inst (
		.pixel_clk(pixel_clk), .reset(reset), .frame_tick(frame_tick),
		.speed_x(speed_x), .speed_y(speed_y), .ball(ball_a));

	ball_motion #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BALL_SIZE(BALL_SIZE),
		.START_X(H_ACTIVE / 2), .START_Y(V_ACTIVE / 2)) ball_b_inst (
		.pixel_clk(pixel_clk), .reset(reset), .frame_tick(frame_tick),
		.speed_x(speed_x), .speed_y(speed_y), .ball(ball_b));

	round_puck #(.BALL_SIZE(BALL_SIZE), .COLOR(pong_pkg::COLOR_BALL_A)) puck_a_inst (
		.pixel_clk(pixel_clk), .raster(raster), .ball(ball_a), .pixel(puck_a_pixel));

	round_puck #(.BALL_SIZE(BALL_SIZE), .COLOR(pong_pkg::COLOR_BALL_B)) puck_b_inst (
		.pixel_clk(pixel_clk), .raster(raster), .ball(ball_b), .pixel(puck_b_pixel));

	paddle_motion #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PADDLE_SIZE(PADDLE_SIZE),
		.PADDLE_STEP(PADDLE_STEP)) paddle_inst (
		.pixel_clk(pixel_clk), .reset(reset), .frame_tick(frame_tick), .up(up),
		.down(down), .left(left), .right(right), .paddle_x(paddle_x), .paddle_y(paddle_y));

	////////////////////////////////////////
	// paddle box, two stages to match the pucks
	assign paddle_x_end = {1'b0, paddle_x} + 12'(PADDLE_SIZE);
	assign paddle_y_end = {1'b0, paddle_y} + 11'(PADDLE_SIZE);

	always_ff @(posedge pixel_clk) begin
		paddle_hit_q   <= (raster.hcount >= paddle_x) && ({1'b0, raster.hcount} < paddle_x_end)
			&& (raster.vcount >= paddle_y) && ({1'b0, raster.vcount} < paddle_y_end);
		paddle_pixel_q <= paddle_hit_q ? pong_pkg::COLOR_PADDLE : video_pkg::COLOR_BLACK;
		// syncs and video_on ride along two cycles
		raster_d1      <= raster;
		pong_raster    <= raster_d1;
	end

	// objects may overlap, colours just merge
	assign pong_pixel = puck_a_pixel | puck_b_pixel | paddle_pixel_q;

endmodule

//--- rtl/video_top.sv
`timescale 1ns/1ps

module video_top #(
	parameter int H_ACTIVE    = 1024,
	parameter int H_FP        = 24,
	parameter int H_SYNC      = 136,
	parameter int H_BP        = 160,
	parameter int V_ACTIVE    = 768,
	parameter int V_FP        = 3,
	parameter int V_SYNC      = 6,
	parameter int V_BP        = 29,
	parameter int BALL_SIZE   = 64,
	parameter int PADDLE_SIZE = 20,
	parameter int PADDLE_STEP = 8
) (
	input  logic                pixel_clk,
	input  logic                reset,
	input  video_pkg::pattern_e pattern,
	input  logic [3:0]          pspeed,
	input  logic                up,
	input  logic                down,
	input  logic                left,
	input  logic                right,
	output logic                hsync,
	output logic                vsync,
	output video_pkg::rgb_t     rgb
);

	// top three bits of the active width pick one of eight bars
	localparam int BAR_MSB = $clog2(H_ACTIVE) - 1;

	video_pkg::raster_t raster;
	video_pkg::raster_t pong_raster;
	video_pkg::rgb_t    pong_pixel;
	video_pkg::raster_t src_raster;
	video_pkg::rgb_t    src_pixel;
	logic               border;
	logic [2:0]         bar;

	vga_timing #(.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)) timing_inst (
		.pixel_clk(pixel_clk), .reset(reset), .raster(raster));

	pong_game #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BALL_SIZE(BALL_SIZE),
		.PADDLE_SIZE(PADDLE_SIZE), .PADDLE_STEP(PADDLE_STEP)) pong_game_inst (
		.pixel_clk(pixel_clk), .reset(reset), .up(up), .down(down), .left(left),
		.right(right), .pspeed(pspeed), .raster(raster), .pong_raster(pong_raster),
		.pong_pixel(pong_pixel));

	////////////////////////////////////////
	// test pattern sources
	assign border = (raster.hcount == 0) || (raster.hcount == H_ACTIVE - 1)
		|| (raster.vcount == 0) || (raster.vcount == V_ACTIVE - 1);
	assign bar = raster.hcount[BAR_MSB -: 3];

	always_comb begin
		case (pattern)
			video_pkg::PATTERN_BORDER: begin
				src_raster = raster;
				src_pixel  = border ? video_pkg::COLOR_WHITE : video_pkg::COLOR_BLACK;
			end
			video_pkg::PATTERN_BARS: begin
				src_raster = raster;
				// expand 3/3/2
				src_pixel  = {{3{bar[2]}}, {3{bar[1]}}, {2{bar[0]}}};
			end
			// both pong codes
			default: begin
				src_raster = pong_raster;
				src_pixel  = pong_pixel;
			end
		endcase
	end

	// output register, black outside the visible area
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			rgb   <= video_pkg::COLOR_BLACK;
		end else begin
			hsync <= src_raster.hsync;
			vsync <= src_raster.vsync;
			rgb   <= src_raster.video_on ? src_pixel : video_pkg::COLOR_BLACK;
		end
	end

endmodule

//--- testbench/video_top_tb.sv
`timescale 1ns/1ps

module video_top_tb;

	////////////////////////////////////////
	// small raster, 160 x 105 per frame
	////////////////////////////////////////

	localparam int H_ACTIVE = 128;
	localparam int H_FP = 8;
	localparam int H_SYNC = 16;
	localparam int H_BP = 8;
	localparam int V_ACTIVE = 96;
	localparam int V_FP = 2;
	localparam int V_SYNC = 3;
	localparam int V_BP = 4;
	localparam int BALL_SIZE = 16;
	localparam int PADDLE_SIZE = 8;
	localparam int PADDLE_STEP = 4;
	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// 56 captured frames, plus frames lost to resync after reset or pattern change
	localparam int TIMEOUT_CYCLES = (56 + 12) * FRAME_CYCLES;

	logic                pixel_clk;
	logic                reset;
	video_pkg::pattern_e pattern;
	logic [3:0]          pspeed;
	logic                up;
	logic                down;
	logic                left;
	logic                right;
	logic                hsync;
	logic                vsync;
	video_pkg::rgb_t     rgb;

	int errors;
	int tests_run;
	int tests_failed;
	int reported;
	int last_wait;
	int cycles;
	int seed;
	// one captured visible area
	video_pkg::rgb_t frame [V_ACTIVE][H_ACTIVE];
	// reference model of the scene
	int ball_x [2];
	int ball_y [2];
	bit ball_right [2];
	bit ball_up [2];
	int pad_x;
	int pad_y;

	video_top #(.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
		.BALL_SIZE(BALL_SIZE), .PADDLE_SIZE(PADDLE_SIZE),
		.PADDLE_STEP(PADDLE_STEP)) video_top_inst (
		.pixel_clk(pixel_clk), .reset(reset), .pattern(pattern), .pspeed(pspeed),
		.up(up), .down(down), .left(left), .right(right),
		.hsync(hsync), .vsync(vsync), .rgb(rgb));

	initial begin
		pixel_clk = 1'b0;
		forever #50 pixel_clk = ~pixel_clk;
	end

	// watchdog
	always @(posedge pixel_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, test did not complete", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic void note_mismatch(string sig, int h, int v, logic [7:0] got,
		logic [7:0] exp);
		errors++;
		// only the first few per test
		if (reported < 8)
			$display("mismatch %s at (%0d,%0d): got %h expected %h", sig, h, v, got, exp);
		reported++;
	endfunction

	task automatic apply_reset();
		@(negedge pixel_clk);
		reset = 1'b1;
		repeat (4) @(negedge pixel_clk);
		// outputs idle while reset is held
		assert (hsync === 1'b1) else note_mismatch("hsync", 0, 0, hsync, 1'b1);
		assert (vsync === 1'b1) else note_mismatch("vsync", 0, 0, vsync, 1'b1);
		assert (rgb === video_pkg::COLOR_BLACK)
			else note_mismatch("rgb", 0, 0, rgb, video_pkg::COLOR_BLACK);
		reset = 1'b0;
	endtask

	// latency differs per path, let the outputs settle for a line
	task automatic select_pattern(video_pkg::pattern_e p);
		pattern = p;
		repeat (H_TOTAL) @(negedge pixel_clk);
	endtask

	// wait for vsync fall at the outputs, then record one frame
	task automatic capture_frame();
		logic vs_prev;
		logic exp_hs;
		logic exp_vs;
		int   h;
		int   v;
		int   i;
		last_wait = 0;
		do begin
			vs_prev = vsync;
			@(negedge pixel_clk);
			last_wait++;
		end while (!(vs_prev && !vsync));
		// vsync falls at the first pixel of line V_ACTIVE+V_FP
		h = 0;
		v = V_ACTIVE + V_FP;
		for (i = 0; i < FRAME_CYCLES; i++) begin
			if (i > 0) begin
				@(negedge pixel_clk);
				h++;
				if (h == H_TOTAL) begin
					h = 0;
					v = (v == V_TOTAL - 1) ? 0 : v + 1;
				end
			end
			exp_hs = !(h >= H_ACTIVE + H_FP && h < H_ACTIVE + H_FP + H_SYNC);
			exp_vs = !(v >= V_ACTIVE + V_FP && v < V_ACTIVE + V_FP + V_SYNC);
			assert (hsync === exp_hs) else note_mismatch("hsync", h, v, hsync, exp_hs);
			assert (vsync === exp_vs) else note_mismatch("vsync", h, v, vsync, exp_vs);
			if (h < H_ACTIVE && v < V_ACTIVE)
				frame[v][h] = rgb;
			else
				assert (rgb === video_pkg::COLOR_BLACK)
					else note_mismatch("rgb", h, v, rgb, video_pkg::COLOR_BLACK);
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	task automatic reset_model();
		ball_x = '{H_ACTIVE / 4, H_ACTIVE / 2};
		ball_y = '{V_ACTIVE / 4, V_ACTIVE / 2};
		ball_right = '{1'b0, 1'b0};
		ball_up = '{1'b1, 1'b1};
		pad_x = H_ACTIVE - 2 * PADDLE_SIZE;
		pad_y = V_ACTIVE - 2 * PADDLE_SIZE;
	endtask

	// step, clamp at the limit and reverse
	task automatic step_balls(int sx, int sy);
		int nx;
		int ny;
		for (int b = 0; b < 2; b++) begin
			nx = ball_right[b] ? ball_x[b] + sx : ball_x[b] - sx;
			ny = ball_up[b] ? ball_y[b] - sy : ball_y[b] + sy;
			if (nx > H_ACTIVE - BALL_SIZE) begin
				ball_x[b] = H_ACTIVE - BALL_SIZE;
				ball_right[b] = 1'b0;
			end else if (nx < 0) begin
				ball_x[b] = 0;
				ball_right[b] = 1'b1;
			end else
				ball_x[b] = nx;
			if (ny < 0) begin
				ball_y[b] = 0;
				ball_up[b] = 1'b0;
			end else if (ny > V_ACTIVE - BALL_SIZE) begin
				ball_y[b] = V_ACTIVE - BALL_SIZE;
				ball_up[b] = 1'b1;
			end else
				ball_y[b] = ny;
		end
	endtask

	// whole step or nothing, up and left win
	task automatic step_paddle(bit go_up, bit go_down, bit go_left, bit go_right);
		int nx;
		int ny;
		ny = go_up ? pad_y - PADDLE_STEP : (go_down ? pad_y + PADDLE_STEP : pad_y);
		nx = go_left ? pad_x - PADDLE_STEP : (go_right ? pad_x + PADDLE_STEP : pad_x);
		if (ny >= 0 && ny <= V_ACTIVE - PADDLE_SIZE)
			pad_y = ny;
		if (nx >= 0 && nx <= H_ACTIVE - PADDLE_SIZE)
			pad_x = nx;
	endtask

	function automatic video_pkg::rgb_t expected_pixel(video_pkg::pattern_e mode, int h, int v);
		video_pkg::rgb_t px;
		logic [2:0]      k;
		int              r;
		int              dx;
		int              dy;
		px = video_pkg::COLOR_BLACK;
		r = BALL_SIZE / 2;
		case (mode)
			video_pkg::PATTERN_BORDER:
				if (h == 0 || h == H_ACTIVE - 1 || v == 0 || v == V_ACTIVE - 1)
					px = video_pkg::COLOR_WHITE;
			video_pkg::PATTERN_BARS: begin
				// eight equal bars, index expanded 3/3/2
				k = 3'(h / (H_ACTIVE / 8));
				px = {k[2] ? 3'b111 : 3'b000, k[1] ? 3'b111 : 3'b000, k[0] ? 2'b11 : 2'b00};
			end
			default: begin
				for (int b = 0; b < 2; b++) begin
					dx = h - (ball_x[b] + r);
					dy = v - (ball_y[b] + r);
					if (dx * dx + dy * dy <= r * r)
						px |= (b == 0) ? pong_pkg::COLOR_BALL_A : pong_pkg::COLOR_BALL_B;
				end
				if (h >= pad_x && h < pad_x + PADDLE_SIZE && v >= pad_y
					&& v < pad_y + PADDLE_SIZE)
					px |= pong_pkg::COLOR_PADDLE;
			end
		endcase
		return px;
	endfunction

	task automatic check_frame(video_pkg::pattern_e mode);
		video_pkg::rgb_t exp;
		for (int v = 0; v < V_ACTIVE; v++)
			for (int h = 0; h < H_ACTIVE; h++) begin
				exp = expected_pixel(mode, h, v);
				assert (frame[v][h] === exp) else note_mismatch("rgb", h, v, frame[v][h], exp);
			end
	endtask

	task automatic finish_test(string name, int start);
		tests_run++;
		if (errors != start)
			tests_failed++;
		$display("test %-14s %s, %0d errors", name, (errors == start) ? "ok" : "FAILED",
			errors - start);
		reported = 0;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_raster();
		int start;
		start = errors;
		capture_frame();
		// next edge must follow straight on, one frame later
		capture_frame();
		assert (last_wait == 1) else begin
			errors++;
			$display("vsync period is not %0d cycles, edge came %0d cycles late",
				FRAME_CYCLES, last_wait - 1);
		end
		finish_test("raster", start);
	endtask

	task automatic test_pattern(video_pkg::pattern_e p, string name);
		int start;
		start = errors;
		select_pattern(p);
		capture_frame();
		check_frame(p);
		finish_test(name, start);
	endtask

	task automatic test_pong_reset();
		int start;
		start = errors;
		pattern = video_pkg::PATTERN_PONG;
		pspeed = 4'd0;
		apply_reset();
		reset_model();
		capture_frame();
		check_frame(video_pkg::PATTERN_PONG);
		// alternate code takes the same path
		select_pattern(video_pkg::PATTERN_PONG_ALT);
		capture_frame();
		check_frame(video_pkg::PATTERN_PONG);
		finish_test("pong_reset", start);
	endtask

	task automatic test_puck_motion();
		int         start;
		int         r;
		logic [3:0] prev;
		start = errors;
		prev = pspeed;
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			// takes effect one frame after the capture below
			pspeed = r[3:0];
			capture_frame();
			step_balls(2 * prev[3:2], 2 * prev[1:0]);
			check_frame(video_pkg::PATTERN_PONG);
			prev = r[3:0];
		end
		finish_test("puck_motion", start);
	endtask

	task automatic test_paddle_motion();
		int start;
		start = errors;
		pattern = video_pkg::PATTERN_PONG;
		pspeed = 4'd0;
		apply_reset();
		reset_model();
		// all four held, up and left must win
		{up, down, left, right} = 4'b1111;
		for (int i = 0; i < 30; i++) begin
			capture_frame();
			step_paddle(1'b1, 1'b1, 1'b1, 1'b1);
			check_frame(video_pkg::PATTERN_PONG);
		end
		{up, down, left, right} = 4'b0000;
		finish_test("paddle_motion", start);
	endtask

	initial begin
		seed = 32'h6d12eb3e;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reported = 0;
		cycles = 0;
		reset = 1'b1;
		pattern = video_pkg::PATTERN_PONG;
		pspeed = 4'd0;
		{up, down, left, right} = 4'b0000;
		apply_reset();
		test_raster();
		test_pattern(video_pkg::PATTERN_BORDER, "border");
		test_pattern(video_pkg::PATTERN_BARS, "bars");
		test_pong_reset();
		test_puck_motion();
		test_paddle_motion();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- video_top.f
rtl/video_pkg.sv
rtl/pong_pkg.sv
rtl/vga_timing.sv
rtl/ball_motion.sv
rtl/paddle_motion.sv
rtl/round_puck.sv
rtl/pong_game.sv
rtl/video_top.sv
testbench/video_top_tb.sv
